//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_rvfi_trace
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/operand_extract.sv
/*
  Pulls the immediate, control target and memory data out of a retired instruction.
  Purely combinational; the decoded mnemonic selects the immediate format.
*/
module operand_extract (
  input  rvfi_trace_pkg::retire_t   retire,
  input  rvfi_trace_pkg::mnemonic_e mnemonic,
  output rvfi_trace_pkg::operand_t  operand
);
  import rvfi_trace_pkg::*;

  logic [XLEN-1:0] insn;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic            is_branch;

  assign insn  = retire.insn;
  assign imm_i = {{(XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_s = {{(XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{(XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  // U-type immediate kept right-aligned, not shifted into place
  assign imm_u = {{(XLEN-20){1'b0}}, insn[31:12]};

  assign is_branch = mnemonic inside {MN_BEQ, MN_BNE, MN_BLT, MN_BGE, MN_BLTU, MN_BGEU};

  always_comb begin
    case (mnemonic)
      MN_ADDI, MN_SLTI, MN_SLTIU, MN_XORI, MN_ORI, MN_ANDI,
      MN_LB, MN_LH, MN_LW, MN_LBU, MN_LHU, MN_JALR:
        operand.imm = imm_i;
      MN_SLLI, MN_SRLI, MN_SRAI:
        operand.imm = {{(XLEN-5){1'b0}}, insn[24:20]};
      MN_SB, MN_SH, MN_SW:
        operand.imm = imm_s;
      MN_BEQ, MN_BNE, MN_BLT, MN_BGE, MN_BLTU, MN_BGEU:
        operand.imm = imm_b;
      MN_LUI, MN_AUIPC:
        operand.imm = imm_u;
      // CSR address as a plain number
      MN_CSRRW, MN_CSRRS, MN_CSRRC, MN_CSRRWI, MN_CSRRSI, MN_CSRRCI:
        operand.imm = {{(XLEN-12){1'b0}}, insn[31:20]};
      // Predecessor and successor sets
      MN_FENCE:
        operand.imm = {{(XLEN-8){1'b0}}, insn[27:20]};
      default:
        operand.imm = '0;
    endcase
  end

  always_comb begin
    if (is_branch) begin
      // Next PC does not show the taken target for a not-taken branch
      operand.target = retire.pc_rdata + imm_b;
    end else if (mnemonic inside {MN_JAL, MN_JALR}) begin
      operand.target = retire.pc_wdata;
    end else if (mnemonic inside {MN_CSRRWI, MN_CSRRSI, MN_CSRRCI}) begin
      operand.target = {{(XLEN-5){1'b0}}, insn[19:15]};
    end else begin
      operand.target = '0;
    end
  end

  assign operand.mem_data = (retire.mem_wmask != '0) ? retire.mem_wdata : retire.mem_rdata;

  // Holds only while the core retires from halfword-aligned PCs
  always_comb begin
    if (is_branch) begin
      assert final (operand.target[0] == 1'b0)
        else $error("odd branch target %h from pc %h", operand.target, retire.pc_rdata);
    end
  end

endmodule

//--- design/retire_decoder.sv
/*
  Classifies a retired instruction word into a mnemonic and the operands it used.
  Purely combinational; compressed words are flagged but not decoded further.
*/
module retire_decoder (
  input  logic [rvfi_trace_pkg::XLEN-1:0] insn,
  output rvfi_trace_pkg::decode_t         decode
);
  import rvfi_trace_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       compressed;
  mnemonic_e  mnemonic;
  access_t    access;

  assign opcode     = opcode_e'(insn[6:0]);
  assign funct3     = insn[14:12];
  assign funct7     = insn[31:25];
  assign compressed = (insn[1:0] != 2'b11);

  always_comb begin
    mnemonic = MN_INVALID;
    if (compressed) begin
      mnemonic = MN_COMPRESSED;
    end else begin
      case (opcode)
        OPC_LUI:   mnemonic = MN_LUI;
        OPC_AUIPC: mnemonic = MN_AUIPC;
        OPC_JAL:   mnemonic = MN_JAL;
        OPC_JALR: begin
          if (funct3 == 3'b000) begin
            mnemonic = MN_JALR;
          end
        end
        OPC_BRANCH: begin
          case (funct3)
            3'b000:  mnemonic = MN_BEQ;
            3'b001:  mnemonic = MN_BNE;
            3'b100:  mnemonic = MN_BLT;
            3'b101:  mnemonic = MN_BGE;
            3'b110:  mnemonic = MN_BLTU;
            3'b111:  mnemonic = MN_BGEU;
            default: mnemonic = MN_INVALID;
          endcase
        end
        // Widths 011, 110 and 111 are not legal on RV32
        OPC_LOAD: begin
          case (funct3)
            3'b000:  mnemonic = MN_LB;
            3'b001:  mnemonic = MN_LH;
            3'b010:  mnemonic = MN_LW;
            3'b100:  mnemonic = MN_LBU;
            3'b101:  mnemonic = MN_LHU;
            default: mnemonic = MN_INVALID;
          endcase
        end
        OPC_STORE: begin
          case (funct3)
            3'b000:  mnemonic = MN_SB;
            3'b001:  mnemonic = MN_SH;
            3'b010:  mnemonic = MN_SW;
            default: mnemonic = MN_INVALID;
          endcase
        end
        OPC_OP_IMM: begin
          case (funct3)
            3'b000: mnemonic = MN_ADDI;
            3'b010: mnemonic = MN_SLTI;
            3'b011: mnemonic = MN_SLTIU;
            3'b100: mnemonic = MN_XORI;
            3'b110: mnemonic = MN_ORI;
            3'b111: mnemonic = MN_ANDI;
            3'b001: mnemonic = (funct7 == 7'b0000000) ? MN_SLLI : MN_INVALID;
            3'b101: begin
              if (funct7 == 7'b0000000) begin
                mnemonic = MN_SRLI;
              end else if (funct7 == 7'b0100000) begin
                mnemonic = MN_SRAI;
              end
            end
            default: mnemonic = MN_INVALID;
          endcase
        end
        OPC_OP: begin
          case ({funct7, funct3})
            {7'b0000000, 3'b000}: mnemonic = MN_ADD;
            {7'b0100000, 3'b000}: mnemonic = MN_SUB;
            {7'b0000000, 3'b001}: mnemonic = MN_SLL;
            {7'b0000000, 3'b010}: mnemonic = MN_SLT;
            {7'b0000000, 3'b011}: mnemonic = MN_SLTU;
            {7'b0000000, 3'b100}: mnemonic = MN_XOR;
            {7'b0000000, 3'b101}: mnemonic = MN_SRL;
            {7'b0100000, 3'b101}: mnemonic = MN_SRA;
            {7'b0000000, 3'b110}: mnemonic = MN_OR;
            {7'b0000000, 3'b111}: mnemonic = MN_AND;
            // RV32M shares the OP opcode with funct7 = 1
            {7'b0000001, 3'b000}: mnemonic = MN_MUL;
            {7'b0000001, 3'b001}: mnemonic = MN_MULH;
            {7'b0000001, 3'b010}: mnemonic = MN_MULHSU;
            {7'b0000001, 3'b011}: mnemonic = MN_MULHU;
            {7'b0000001, 3'b100}: mnemonic = MN_DIV;
            {7'b0000001, 3'b101}: mnemonic = MN_DIVU;
            {7'b0000001, 3'b110}: mnemonic = MN_REM;
            {7'b0000001, 3'b111}: mnemonic = MN_REMU;
            default:              mnemonic = MN_INVALID;
          endcase
        end
        OPC_MISC_MEM: begin
          case (funct3)
            3'b000:  mnemonic = MN_FENCE;
            3'b001:  mnemonic = MN_FENCE_I;
            default: mnemonic = MN_INVALID;
          endcase
        end
        OPC_SYSTEM: begin
          case (funct3)
            3'b000: begin
              // Privileged ops are matched on the full word
              case (insn)
                32'h0000_0073: mnemonic = MN_ECALL;
                32'h0010_0073: mnemonic = MN_EBREAK;
                32'h3020_0073: mnemonic = MN_MRET;
                32'h7b20_0073: mnemonic = MN_DRET;
                32'h1050_0073: mnemonic = MN_WFI;
                default:       mnemonic = MN_INVALID;
              endcase
            end
            3'b001:  mnemonic = MN_CSRRW;
            3'b010:  mnemonic = MN_CSRRS;
            3'b011:  mnemonic = MN_CSRRC;
            3'b101:  mnemonic = MN_CSRRWI;
            3'b110:  mnemonic = MN_CSRRSI;
            3'b111:  mnemonic = MN_CSRRCI;
            default: mnemonic = MN_INVALID;
          endcase
        end
        default: mnemonic = MN_INVALID;
      endcase
    end
  end

  // Operand usage follows the instruction format
  always_comb begin
    case (mnemonic)
      MN_ADD, MN_SUB, MN_SLL, MN_SLT, MN_SLTU, MN_XOR, MN_SRL, MN_SRA, MN_OR, MN_AND,
      MN_MUL, MN_MULH, MN_MULHSU, MN_MULHU, MN_DIV, MN_DIVU, MN_REM, MN_REMU:
        access = ACC_REG_REG;
      MN_ADDI, MN_SLTI, MN_SLTIU, MN_XORI, MN_ORI, MN_ANDI, MN_SLLI, MN_SRLI, MN_SRAI,
      MN_JALR, MN_CSRRW, MN_CSRRS, MN_CSRRC:
        access = ACC_REG_IMM;
      MN_CSRRWI, MN_CSRRSI, MN_CSRRCI, MN_LUI, MN_AUIPC, MN_JAL:
        access = ACC_RD;
      MN_BEQ, MN_BNE, MN_BLT, MN_BGE, MN_BLTU, MN_BGEU:
        access = ACC_BRANCH;
      MN_LB, MN_LH, MN_LW, MN_LBU, MN_LHU:
        access = ACC_LOAD;
      MN_SB, MN_SH, MN_SW:
        access = ACC_STORE;
      default:
        access = ACC_NONE;
    endcase
  end

  assign decode = '{mnemonic: mnemonic, access: access, compressed: compressed};

  // Words we cannot decode must never claim operands
  always_comb begin
    if (decode.mnemonic inside {MN_INVALID, MN_COMPRESSED}) begin
      assert final (decode.access == ACC_NONE)
        else $error("operand access reported for undecoded word %h", insn);
    end
  end

endmodule

//--- design/rvfi_trace.sv
/*
  Retirement tracer top level. Decodes each retired instruction from the
  RVFI port and emits one registered trace record a cycle later.
*/
module rvfi_trace (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          valid,
  input  rvfi_trace_pkg::retire_t       retire,
  output logic                          trace_valid,
  output rvfi_trace_pkg::trace_record_t record
);
  import rvfi_trace_pkg::*;

  decode_t  decode;
  operand_t operand;

  // Classification of the raw word
  retire_decoder u_decoder (
    .insn   (retire.insn),
    .decode (decode)
  );

  operand_extract u_extract (
    .retire   (retire),
    .mnemonic (decode.mnemonic),
    .operand  (operand)
  );

  // Single register stage, no back-pressure
  trace_stage u_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid       (valid),
    .retire      (retire),
    .decode      (decode),
    .operand     (operand),
    .trace_valid (trace_valid),
    .record      (record)
  );

endmodule

//--- design/rvfi_trace_pkg.sv
/*
  Shared widths, encodings and record types for the RVFI retirement tracer.
  Modules import this package in their bodies and use scoped names in ports.
*/
package rvfi_trace_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned CYCLE_W    = 32;
  localparam int unsigned MASK_W     = XLEN / 8;

  // Major opcodes of the 32-bit encoding space
  typedef enum logic [6:0] {
    OPC_LUI      = 7'h37,
    OPC_AUIPC    = 7'h17,
    OPC_JAL      = 7'h6f,
    OPC_JALR     = 7'h67,
    OPC_BRANCH   = 7'h63,
    OPC_LOAD     = 7'h03,
    OPC_STORE    = 7'h23,
    OPC_OP_IMM   = 7'h13,
    OPC_OP       = 7'h33,
    OPC_MISC_MEM = 7'h0f,
    OPC_SYSTEM   = 7'h73
  } opcode_e;

  // One code per traced instruction
  typedef enum logic [7:0] {
    MN_LUI = 8'd0, MN_AUIPC, MN_JAL, MN_JALR,
    MN_BEQ, MN_BNE, MN_BLT, MN_BGE, MN_BLTU, MN_BGEU,
    MN_LB, MN_LH, MN_LW, MN_LBU, MN_LHU,
    MN_SB, MN_SH, MN_SW,
    MN_ADDI, MN_SLTI, MN_SLTIU, MN_XORI, MN_ORI, MN_ANDI,
    MN_SLLI, MN_SRLI, MN_SRAI,
    MN_ADD, MN_SUB, MN_SLL, MN_SLT, MN_SLTU,
    MN_XOR, MN_SRL, MN_SRA, MN_OR, MN_AND,
    MN_MUL, MN_MULH, MN_MULHSU, MN_MULHU,
    MN_DIV, MN_DIVU, MN_REM, MN_REMU,
    MN_CSRRW, MN_CSRRS, MN_CSRRC, MN_CSRRWI, MN_CSRRSI, MN_CSRRCI,
    MN_ECALL, MN_EBREAK, MN_MRET, MN_DRET, MN_WFI,
    MN_FENCE, MN_FENCE_I,
    MN_COMPRESSED = 8'hfe,
    MN_INVALID    = 8'hff
  } mnemonic_e;

  // Which operands an instruction touched
  typedef struct packed {
    logic rs1;
    logic rs2;
    logic rd;
    logic mem;
  } access_t;

  localparam access_t ACC_NONE    = '{rs1: 1'b0, rs2: 1'b0, rd: 1'b0, mem: 1'b0};
  localparam access_t ACC_REG_REG = '{rs1: 1'b1, rs2: 1'b1, rd: 1'b1, mem: 1'b0};
  localparam access_t ACC_REG_IMM = '{rs1: 1'b1, rs2: 1'b0, rd: 1'b1, mem: 1'b0};
  localparam access_t ACC_RD      = '{rs1: 1'b0, rs2: 1'b0, rd: 1'b1, mem: 1'b0};
  localparam access_t ACC_BRANCH  = '{rs1: 1'b1, rs2: 1'b1, rd: 1'b0, mem: 1'b0};
  localparam access_t ACC_LOAD    = '{rs1: 1'b1, rs2: 1'b0, rd: 1'b1, mem: 1'b1};
  localparam access_t ACC_STORE   = '{rs1: 1'b1, rs2: 1'b1, rd: 1'b0, mem: 1'b1};

  // Retirement port as seen from the core
  typedef struct packed {
    logic [XLEN-1:0]       insn;
    logic [XLEN-1:0]       pc_rdata;
    logic [XLEN-1:0]       pc_wdata;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rs1_rdata;
    logic [XLEN-1:0]       rs2_rdata;
    logic [XLEN-1:0]       rd_wdata;
    logic [XLEN-1:0]       mem_addr;
    logic [MASK_W-1:0]     mem_rmask;
    logic [MASK_W-1:0]     mem_wmask;
    logic [XLEN-1:0]       mem_rdata;
    logic [XLEN-1:0]       mem_wdata;
  } retire_t;

  typedef struct packed {
    mnemonic_e mnemonic;
    access_t   access;
    logic      compressed;
  } decode_t;

  typedef struct packed {
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] mem_data;
  } operand_t;

  // One entry per retired instruction
  typedef struct packed {
    decode_t               decode;
    operand_t              operand;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rs1_rdata;
    logic [XLEN-1:0]       rs2_rdata;
    logic [XLEN-1:0]       rd_wdata;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       insn;
    logic [XLEN-1:0]       mem_addr;
    logic [CYCLE_W-1:0]    cycle;
  } trace_record_t;

endpackage

//--- design/trace_stage.sv
/*
  Output register of the tracer. Captures one record per sampled valid,
  stamped with a free-running cycle counter, and pulses trace_valid.
*/
module trace_stage (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          valid,
  input  rvfi_trace_pkg::retire_t       retire,
  input  rvfi_trace_pkg::decode_t       decode,
  input  rvfi_trace_pkg::operand_t      operand,
  output logic                          trace_valid,
  output rvfi_trace_pkg::trace_record_t record
);
  import rvfi_trace_pkg::*;

  logic [CYCLE_W-1:0] cycle_q;
  trace_record_t      record_d;

  // Counts every edge since reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  always_comb begin
    record_d.decode    = decode;
    record_d.operand   = operand;
    record_d.rs1_addr  = retire.rs1_addr;
    record_d.rs2_addr  = retire.rs2_addr;
    record_d.rd_addr   = retire.rd_addr;
    record_d.rs1_rdata = retire.rs1_rdata;
    record_d.rs2_rdata = retire.rs2_rdata;
    record_d.rd_wdata  = retire.rd_wdata;
    record_d.pc        = retire.pc_rdata;
    record_d.insn      = retire.insn;
    record_d.mem_addr  = retire.mem_addr;
    record_d.cycle     = cycle_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trace_valid <= 1'b0;
      record      <= '0;
    end else begin
      trace_valid <= valid;
      // Record holds its last value between retirements
      if (valid) begin
        record <= record_d;
      end
    end
  end

  valid_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(trace_valid))
    else $error("trace_valid is unknown");

endmodule

//--- project.f
+incdir+include
design/rvfi_trace_pkg.sv
design/retire_decoder.sv
design/operand_extract.sv
design/trace_stage.sv
design/rvfi_trace.sv
testbench/tb_rvfi_trace.sv

//--- include/tb_vectors.svh
/*
  Stimulus table for the tracer testbench. One row per retired instruction,
  with the decode results the tracer is expected to report for it.
*/
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: insn, pc_rdata, pc_wdata, mem_rmask, mem_wmask, mnemonic,
// access {rs1, rs2, rd, mem}, imm, target
typedef struct packed {
  logic [31:0] insn;
  logic [31:0] pc;
  logic [31:0] pc_wdata;
  logic [3:0]  rmask;
  logic [3:0]  wmask;
  mnemonic_e   mn;
  access_t     acc;
  logic [31:0] imm;
  logic [31:0] target;
} vector_t;

localparam int NUM_VECTORS = 25;

localparam vector_t VECTORS [NUM_VECTORS] = '{
  '{32'h123452b7, 32'h1000, 32'h1004, 4'h0, 4'h0, MN_LUI, 4'b0010, 32'h12345, 32'h0},
  '{32'hfffff097, 32'h1004, 32'h1008, 4'h0, 4'h0, MN_AUIPC, 4'b0010, 32'hfffff, 32'h0},
  '{32'h100000ef, 32'h1008, 32'h1108, 4'h0, 4'h0, MN_JAL, 4'b0010, 32'h0, 32'h1108},
  '{32'h008100e7, 32'h1108, 32'h2468, 4'h0, 4'h0, MN_JALR, 4'b1010, 32'h8, 32'h2468},
  // Backward branch, not taken
  '{32'hfe2088e3, 32'h2000, 32'h2004, 4'h0, 4'h0, MN_BEQ, 4'b1100, 32'hfffffff0, 32'h1ff0},
  '{32'h00419463, 32'h3000, 32'h3008, 4'h0, 4'h0, MN_BNE, 4'b1100, 32'h8, 32'h3008},
  '{32'h00c32283, 32'h3008, 32'h300c, 4'hf, 4'h0, MN_LW, 4'b1011, 32'hc, 32'h0},
  '{32'hfff44383, 32'h300c, 32'h3010, 4'h1, 4'h0, MN_LBU, 4'b1011, 32'hffffffff, 32'h0},
  // Load width 011 is RV64 only
  '{32'h00c33283, 32'h3010, 32'h3014, 4'h0, 4'h0, MN_INVALID, 4'b0000, 32'h0, 32'h0},
  '{32'h0020aa23, 32'h3014, 32'h3018, 4'h0, 4'hf, MN_SW, 4'b1101, 32'h14, 32'h0},
  '{32'hfe320e23, 32'h3018, 32'h301c, 4'h0, 4'h1, MN_SB, 4'b1101, 32'hfffffffc, 32'h0},
  '{32'hffb10093, 32'h301c, 32'h3020, 4'h0, 4'h0, MN_ADDI, 4'b1010, 32'hfffffffb, 32'h0},
  '{32'h40725193, 32'h3020, 32'h3024, 4'h0, 4'h0, MN_SRAI, 4'b1010, 32'h7, 32'h0},
  '{32'h003100b3, 32'h3024, 32'h3028, 4'h0, 4'h0, MN_ADD, 4'b1110, 32'h0, 32'h0},
  '{32'h40628233, 32'h3028, 32'h302c, 4'h0, 4'h0, MN_SUB, 4'b1110, 32'h0, 32'h0},
  '{32'h029403b3, 32'h302c, 32'h3030, 4'h0, 4'h0, MN_MUL, 4'b1110, 32'h0, 32'h0},
  '{32'h02c5d533, 32'h3030, 32'h3034, 4'h0, 4'h0, MN_DIVU, 4'b1110, 32'h0, 32'h0},
  '{32'h300110f3, 32'h3034, 32'h3038, 4'h0, 4'h0, MN_CSRRW, 4'b1010, 32'h300, 32'h0},
  '{32'h3042e1f3, 32'h3038, 32'h303c, 4'h0, 4'h0, MN_CSRRSI, 4'b0010, 32'h304, 32'h5},
  '{32'h00000073, 32'h303c, 32'h0100, 4'h0, 4'h0, MN_ECALL, 4'b0000, 32'h0, 32'h0},
  '{32'h30200073, 32'h0100, 32'h3040, 4'h0, 4'h0, MN_MRET, 4'b0000, 32'h0, 32'h0},
  '{32'h0ff0000f, 32'h3040, 32'h3044, 4'h0, 4'h0, MN_FENCE, 4'b0000, 32'hff, 32'h0},
  '{32'h0000100f, 32'h3044, 32'h3048, 4'h0, 4'h0, MN_FENCE_I, 4'b0000, 32'h0, 32'h0},
  // c.li a0, 0
  '{32'h00004501, 32'h3048, 32'h304a, 4'h0, 4'h0, MN_COMPRESSED, 4'b0000, 32'h0, 32'h0},
  '{32'h0000002b, 32'h304a, 32'h304e, 4'h0, 4'h0, MN_INVALID, 4'b0000, 32'h0, 32'h0}
};

`endif

//--- testbench/tb_rvfi_trace.sv
/*
  Testbench for the retirement tracer. Applies the vector table through the
  retirement port and checks every trace record against the expected decode.
*/
module tb_rvfi_trace;
  import rvfi_trace_pkg::*;

  `include "tb_vectors.svh"

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DELAY  = 1;
  localparam int TIMEOUT      = (NUM_VECTORS * 10 + RESET_CYCLES) * CLK_PERIOD;

  // One retirement waiting for its record
  typedef struct packed {
    logic [15:0]        idx;
    logic [CYCLE_W-1:0] cycle;
    retire_t            ret;
  } pending_t;

  logic               clk_i;
  logic               rst_ni;
  logic               valid;
  retire_t            retire;
  logic               trace_valid;
  trace_record_t      record;
  logic [31:0]        rng_state;
  logic [CYCLE_W-1:0] edge_count;
  pending_t           pending[$];
  int                 errors;
  int                 row_errors;
  int                 tests;
  int                 tests_failed;

  rvfi_trace uut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid       (valid),
    .retire      (retire),
    .trace_valid (trace_valid),
    .record      (record)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Edges seen since reset, the expected cycle stamp
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      edge_count <= '0;
    end else begin
      edge_count <= edge_count + 1'b1;
    end
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  task automatic drive_row(input int idx);
    pending_t entry;
    retire.insn      = VECTORS[idx].insn;
    retire.pc_rdata  = VECTORS[idx].pc;
    retire.pc_wdata  = VECTORS[idx].pc_wdata;
    retire.mem_rmask = VECTORS[idx].rmask;
    retire.mem_wmask = VECTORS[idx].wmask;
    retire.rs1_addr  = 5'(next_random());
    retire.rs2_addr  = 5'(next_random());
    retire.rd_addr   = 5'(next_random());
    retire.rs1_rdata = next_random();
    retire.rs2_rdata = next_random();
    retire.rd_wdata  = next_random();
    retire.mem_addr  = next_random();
    retire.mem_rdata = next_random();
    retire.mem_wdata = next_random();
    valid            = 1'b1;
    entry.idx        = 16'(idx);
    entry.cycle      = edge_count;
    entry.ret        = retire;
    pending.push_back(entry);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else begin
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        row_errors++;
      end
  endtask

  task automatic check_record(input pending_t exp);
    vector_t         v;
    logic [XLEN-1:0] mem_exp;
    v          = VECTORS[exp.idx];
    // Stores report the written data, every other row the read data
    mem_exp    = (v.acc.mem && !v.acc.rd) ? exp.ret.mem_wdata : exp.ret.mem_rdata;
    row_errors = 0;
    assert (trace_valid === 1'b1)
      else begin
        $display("mismatch at %0t: no trace_valid pulse for test %0d", $time, exp.idx);
        row_errors++;
      end
    check_value("mnemonic", 32'(record.decode.mnemonic), 32'(v.mn));
    check_value("access", 32'(record.decode.access), 32'(v.acc));
    check_value("compressed", 32'(record.decode.compressed), 32'(v.mn == MN_COMPRESSED));
    check_value("imm", record.operand.imm, v.imm);
    check_value("target", record.operand.target, v.target);
    check_value("mem_data", record.operand.mem_data, mem_exp);
    check_value("rs1_addr", 32'(record.rs1_addr), 32'(exp.ret.rs1_addr));
    check_value("rs2_addr", 32'(record.rs2_addr), 32'(exp.ret.rs2_addr));
    check_value("rd_addr", 32'(record.rd_addr), 32'(exp.ret.rd_addr));
    check_value("rs1_rdata", record.rs1_rdata, exp.ret.rs1_rdata);
    check_value("rs2_rdata", record.rs2_rdata, exp.ret.rs2_rdata);
    check_value("rd_wdata", record.rd_wdata, exp.ret.rd_wdata);
    check_value("pc", record.pc, v.pc);
    check_value("insn", record.insn, v.insn);
    check_value("mem_addr", record.mem_addr, exp.ret.mem_addr);
    check_value("cycle", record.cycle, exp.cycle);
    tests++;
    if (row_errors != 0) begin
      tests_failed++;
    end
    errors += row_errors;
    $display("test %0d %s: %s", exp.idx, v.mn.name(), (row_errors == 0) ? "pass" : "fail");
  endtask

  // Outputs are compared at the falling edge, away from the sampling edge
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      assert (trace_valid === 1'b0 && record === '0)
        else begin
          $display("mismatch at %0t: trace_valid or record not cleared during reset", $time);
          errors++;
        end
    end else if (pending.size() != 0 && pending[0].cycle == edge_count - CYCLE_W'(1)) begin
      check_record(pending.pop_front());
    end else begin
      assert (trace_valid === 1'b0)
        else begin
          $display("mismatch at %0t: trace_valid pulse without a sampled valid", $time);
          errors++;
        end
    end
  end

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    valid        = 1'b0;
    retire       = '0;
    rng_state    = 32'hba5a2bfb;
    errors       = 0;
    row_errors   = 0;
    tests        = 0;
    tests_failed = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_ni = 1'b1;
    for (int i = 0; i < NUM_VECTORS; i++) begin
      drive_row(i);
      @(posedge clk_i);
      #DRIVE_DELAY;
      // Idle gap of two cycles after every sixth row
      if (i % 6 == 5) begin
        valid = 1'b0;
        repeat (2) @(posedge clk_i);
        #DRIVE_DELAY;
      end
    end
    valid = 1'b0;
    while (pending.size() != 0) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
    assert (tests == NUM_VECTORS)
      else begin
        $display("only %0d of %0d records were checked", tests, NUM_VECTORS);
        errors++;
      end
    $display("tests run %0d, tests failed %0d, errors %0d", tests, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("watchdog expired with %0d records still pending", pending.size());
    $display("ERRORS FOUND");
    $finish;
  end

endmodule
